/* hw/dcache_pkg.sv */
// data cache shared definitions

package dcache_pkg;

  // byte address is tag | index | offset
  localparam int addr_width  = 16;
  localparam int offset_bits = 3;
  localparam int index_bits  = 4;
  localparam int num_sets    = 1 << index_bits;
  localparam int tag_bits    = addr_width - index_bits - offset_bits;

  // four ways, one 64-bit word per line
  localparam int num_ways   = 4;
  localparam int way_bits   = 2;
  localparam int data_width = 64;

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } cache_op_t;

  // controller FSM
  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_lookup    = 3'd1,
    st_writeback = 3'd2,
    st_refill    = 3'd3,
    st_respond   = 3'd4
  } ctrl_state_t;

endpackage

/* hw/dcache_way.sv */
// cache way storage

`timescale 1ns/10ps

module dcache_way
  import dcache_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic [index_bits-1:0] index,
  input  logic [tag_bits-1:0]   tag,
  input  logic                  write_en,
  input  logic [data_width-1:0] write_data,
  input  logic                  write_dirty,
  output logic                  hit,
  output logic                  line_valid,
  output logic                  line_dirty,
  output logic [tag_bits-1:0]   line_tag,
  output logic [data_width-1:0] line_data
);

  logic [num_sets-1:0]   valid_bits;
  logic [num_sets-1:0]   dirty_bits;
  logic [tag_bits-1:0]   tag_mem  [num_sets];
  logic [data_width-1:0] data_mem [num_sets];

  // addressed entry, read combinationally
  assign line_valid = valid_bits[index];
  assign line_dirty = dirty_bits[index];
  assign line_tag   = tag_mem[index];
  assign line_data  = data_mem[index];
  assign hit        = line_valid && (line_tag == tag);

  // status bits
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (write_en) begin
      valid_bits[index] <= 1'b1;
      dirty_bits[index] <= write_dirty;
    end
  end

  // tag and data arrays
  always_ff @(posedge clock) begin
    if (write_en) begin
      tag_mem[index]  <= tag;
      data_mem[index] <= write_data;
    end
  end

  // the controller must hold a clean latched address on every write
  a_write_index_known: assert property (@(posedge clock) disable iff (reset)
    write_en |-> !$isunknown(index));

endmodule

/* hw/dcache_array.sv */
// four-way set array with pseudo-LRU

`timescale 1ns/10ps

module dcache_array
  import dcache_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic [addr_width-1:0] addr,
  input  logic                  write_en,
  input  logic [way_bits-1:0]   write_way,
  input  logic [data_width-1:0] write_data,
  input  logic                  write_dirty,
  input  logic                  access_en,
  input  logic [way_bits-1:0]   access_way,
  output logic                  hit,
  output logic [way_bits-1:0]   hit_way,
  output logic [data_width-1:0] hit_data,
  output logic [way_bits-1:0]   victim_way,
  output logic                  victim_dirty,
  output logic [tag_bits-1:0]   victim_tag,
  output logic [data_width-1:0] victim_data
);

  logic [index_bits-1:0] index;
  logic [tag_bits-1:0]   tag;
  logic [num_ways-1:0]   way_hit;
  logic [num_ways-1:0]   way_valid;
  logic [num_ways-1:0]   way_dirty;
  logic [tag_bits-1:0]   way_tag  [num_ways];
  logic [data_width-1:0] way_data [num_ways];

  // tree bits per set: a picks the half, b and c pick within it
  logic [num_sets-1:0]   plru_a;
  logic [num_sets-1:0]   plru_b;
  logic [num_sets-1:0]   plru_c;
  logic [way_bits-1:0]   plru_way;

  assign index = addr[offset_bits +: index_bits];
  assign tag   = addr[addr_width-1 -: tag_bits];

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    dcache_way u_way (
      .clock       (clock),
      .reset       (reset),
      .index       (index),
      .tag         (tag),
      .write_en    (write_en && (write_way == way_bits'(w))),
      .write_data  (write_data),
      .write_dirty (write_dirty),
      .hit         (way_hit[w]),
      .line_valid  (way_valid[w]),
      .line_dirty  (way_dirty[w]),
      .line_tag    (way_tag[w]),
      .line_data   (way_data[w])
    );
  end

  // one-hot hit to way number and data
  always_comb begin
    hit_way  = '0;
    hit_data = way_data[0];
    for (int w = 0; w < num_ways; w++) begin
      if (way_hit[w]) begin
        hit_way  = way_bits'(w);
        hit_data = way_data[w];
      end
    end
  end

  assign hit = |way_hit;

  assign plru_way = plru_a[index] ? {1'b1, plru_c[index]} : {1'b0, plru_b[index]};

  // lowest invalid way wins over the tree
  always_comb begin
    victim_way = plru_way;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (!way_valid[w]) begin
        victim_way = way_bits'(w);
      end
    end
  end

  assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
  assign victim_tag   = way_tag[victim_way];
  assign victim_data  = way_data[victim_way];

  // point away from the way just used
  always_ff @(posedge clock) begin
    if (reset) begin
      plru_a <= '0;
      plru_b <= '0;
      plru_c <= '0;
    end else if (access_en) begin
      plru_a[index] <= ~access_way[1];
      if (access_way[1]) begin
        plru_c[index] <= ~access_way[0];
      end else begin
        plru_b[index] <= ~access_way[0];
      end
    end
  end

  // a tag may live in only one way of a set
  a_single_hit: assert property (@(posedge clock) disable iff (reset)
    $onehot0(way_hit));

endmodule

/* hw/req_fifo.sv */
// two-entry request FIFO

`timescale 1ns/10ps

module req_fifo
  import dcache_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  cache_op_t             in_op,
  input  logic [addr_width-1:0] in_addr,
  input  logic [data_width-1:0] in_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output cache_op_t             out_op,
  output logic [addr_width-1:0] out_addr,
  output logic [data_width-1:0] out_data
);

  cache_op_t             op_mem   [2];
  logic [addr_width-1:0] addr_mem [2];
  logic [data_width-1:0] data_mem [2];
  logic                  wr_ptr;
  logic                  rd_ptr;
  logic [1:0]            count;
  logic                  push;
  logic                  pop;

  // full at two entries
  assign in_ready  = count != 2'd2;
  assign out_valid = count != 2'd0;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  assign out_op   = op_mem[rd_ptr];
  assign out_addr = addr_mem[rd_ptr];
  assign out_data = data_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      op_mem[wr_ptr]   <= in_op;
      addr_mem[wr_ptr] <= in_addr;
      data_mem[wr_ptr] <= in_data;
    end
  end

  // a push onto a full buffer leaves count and pointers out of step
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    count <= 2'd2 && ((count == 2'd1) == (wr_ptr != rd_ptr)));

endmodule

/* hw/dcache_ctrl.sv */
// blocking cache controller

`timescale 1ns/10ps

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  fifo_valid,
  output logic                  fifo_ready,
  input  cache_op_t             fifo_op,
  input  logic [addr_width-1:0] fifo_addr,
  input  logic [data_width-1:0] fifo_data,
  output logic                  resp_valid,
  input  logic                  resp_ready,
  output logic [data_width-1:0] resp_data,
  output logic                  mem_req_valid,
  input  logic                  mem_req_ready,
  output logic                  mem_req_write,
  output logic [addr_width-1:0] mem_req_addr,
  output logic [data_width-1:0] mem_req_data,
  input  logic                  mem_resp_valid,
  input  logic [data_width-1:0] mem_resp_data,
  output logic [addr_width-1:0] addr,
  input  logic                  hit,
  input  logic [way_bits-1:0]   hit_way,
  input  logic [data_width-1:0] hit_data,
  input  logic [way_bits-1:0]   victim_way,
  input  logic                  victim_dirty,
  input  logic [tag_bits-1:0]   victim_tag,
  input  logic [data_width-1:0] victim_data,
  output logic                  write_en,
  output logic [way_bits-1:0]   write_way,
  output logic [data_width-1:0] write_data,
  output logic                  write_dirty,
  output logic                  access_en,
  output logic [way_bits-1:0]   access_way
);

  ctrl_state_t           state;
  cache_op_t             req_op;
  logic [addr_width-1:0] req_addr;
  logic [data_width-1:0] req_data;
  logic [way_bits-1:0]   fill_way;
  logic [index_bits-1:0] req_index;
  logic                  mem_req_fire;

  assign addr         = req_addr;
  assign req_index    = req_addr[offset_bits +: index_bits];
  assign fifo_ready   = state == st_idle;
  assign resp_valid   = state == st_respond;
  assign mem_req_fire = mem_req_valid && mem_req_ready;

  // array write and replacement strobes
  always_comb begin
    write_en    = 1'b0;
    write_way   = fill_way;
    write_data  = req_data;
    write_dirty = 1'b1;
    access_en   = 1'b0;
    access_way  = fill_way;
    case (state)
      st_lookup: begin
        if (hit) begin
          // a load hit only touches the tree bits
          write_en   = req_op == op_store;
          write_way  = hit_way;
          access_en  = 1'b1;
          access_way = hit_way;
        end else if (req_op == op_store && !victim_dirty) begin
          write_en   = 1'b1;
          write_way  = victim_way;
          access_en  = 1'b1;
          access_way = victim_way;
        end
      end
      st_writeback: begin
        // store word goes in once the old line has left
        if (mem_req_fire && req_op == op_store) begin
          write_en  = 1'b1;
          access_en = 1'b1;
        end
      end
      st_refill: begin
        if (mem_resp_valid) begin
          write_en    = 1'b1;
          write_data  = mem_resp_data;
          write_dirty = 1'b0;
          access_en   = 1'b1;
        end
      end
      default: write_en = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= st_idle;
      mem_req_valid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (fifo_valid) begin
            state <= st_lookup;
          end
        end
        st_lookup: begin
          if (hit) begin
            state <= (req_op == op_load) ? st_respond : st_idle;
          end else if (victim_dirty) begin
            mem_req_valid <= 1'b1;
            state         <= st_writeback;
          end else if (req_op == op_load) begin
            mem_req_valid <= 1'b1;
            state         <= st_refill;
          end else begin
            state <= st_idle;
          end
        end
        st_writeback: begin
          // loads chain straight into the read request
          if (mem_req_fire) begin
            mem_req_valid <= req_op == op_load;
            state         <= (req_op == op_load) ? st_refill : st_idle;
          end
        end
        st_refill: begin
          if (mem_req_fire) begin
            mem_req_valid <= 1'b0;
          end
          if (mem_resp_valid) begin
            state <= st_respond;
          end
        end
        st_respond: begin
          if (resp_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // request, memory request and response payloads
  always_ff @(posedge clock) begin
    if (fifo_valid && fifo_ready) begin
      req_op   <= fifo_op;
      req_addr <= fifo_addr;
      req_data <= fifo_data;
    end
    if (state == st_lookup) begin
      fill_way <= victim_way;
      if (victim_dirty) begin
        mem_req_write <= 1'b1;
        mem_req_addr  <= {victim_tag, req_index, {offset_bits{1'b0}}};
        mem_req_data  <= victim_data;
      end else begin
        mem_req_write <= 1'b0;
        mem_req_addr  <= {req_addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
      end
      if (hit && req_op == op_load) begin
        resp_data <= hit_data;
      end
    end
    if (state == st_writeback && mem_req_fire) begin
      mem_req_write <= 1'b0;
      mem_req_addr  <= {req_addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
    end
    if (state == st_refill && mem_resp_valid) begin
      resp_data <= mem_resp_data;
    end
  end

  // response held until taken
  a_resp_hold: assert property (@(posedge clock) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data));

endmodule

/* hw/dcache_top.sv */
// data cache top level

`timescale 1ns/10ps

module dcache_top
  import dcache_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  cache_op_t             req_op,
  input  logic [addr_width-1:0] req_addr,
  input  logic [data_width-1:0] req_data,
  output logic                  resp_valid,
  input  logic                  resp_ready,
  output logic [data_width-1:0] resp_data,
  output logic                  mem_req_valid,
  input  logic                  mem_req_ready,
  output logic                  mem_req_write,
  output logic [addr_width-1:0] mem_req_addr,
  output logic [data_width-1:0] mem_req_data,
  input  logic                  mem_resp_valid,
  input  logic [data_width-1:0] mem_resp_data
);

  // FIFO head
  logic                  fifo_valid;
  logic                  fifo_ready;
  cache_op_t             fifo_op;
  logic [addr_width-1:0] fifo_addr;
  logic [data_width-1:0] fifo_data;

  // controller to array
  logic [addr_width-1:0] addr;
  logic                  write_en;
  logic [way_bits-1:0]   write_way;
  logic [data_width-1:0] write_data;
  logic                  write_dirty;
  logic                  access_en;
  logic [way_bits-1:0]   access_way;
  logic                  hit;
  logic [way_bits-1:0]   hit_way;
  logic [data_width-1:0] hit_data;
  logic [way_bits-1:0]   victim_way;
  logic                  victim_dirty;
  logic [tag_bits-1:0]   victim_tag;
  logic [data_width-1:0] victim_data;

  req_fifo u_fifo (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_op     (req_op),
    .in_addr   (req_addr),
    .in_data   (req_data),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .out_op    (fifo_op),
    .out_addr  (fifo_addr),
    .out_data  (fifo_data)
  );

  dcache_ctrl u_ctrl (
    .clock          (clock),
    .reset          (reset),
    .fifo_valid     (fifo_valid),
    .fifo_ready     (fifo_ready),
    .fifo_op        (fifo_op),
    .fifo_addr      (fifo_addr),
    .fifo_data      (fifo_data),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_data      (resp_data),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .mem_req_data   (mem_req_data),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .addr           (addr),
    .hit            (hit),
    .hit_way        (hit_way),
    .hit_data       (hit_data),
    .victim_way     (victim_way),
    .victim_dirty   (victim_dirty),
    .victim_tag     (victim_tag),
    .victim_data    (victim_data),
    .write_en       (write_en),
    .write_way      (write_way),
    .write_data     (write_data),
    .write_dirty    (write_dirty),
    .access_en      (access_en),
    .access_way     (access_way)
  );

  dcache_array u_array (
    .clock        (clock),
    .reset        (reset),
    .addr         (addr),
    .write_en     (write_en),
    .write_way    (write_way),
    .write_data   (write_data),
    .write_dirty  (write_dirty),
    .access_en    (access_en),
    .access_way   (access_way),
    .hit          (hit),
    .hit_way      (hit_way),
    .hit_data     (hit_data),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_data  (victim_data)
  );

endmodule

/* bench/bench_mem.sv */
// test memory responder

`timescale 1ns/10ps

module bench_mem
  import dcache_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  stall,
  input  logic                  mem_req_valid,
  output logic                  mem_req_ready,
  input  logic                  mem_req_write,
  input  logic [addr_width-1:0] mem_req_addr,
  input  logic [data_width-1:0] mem_req_data,
  output logic                  mem_resp_valid,
  output logic [data_width-1:0] mem_resp_data
);

  // sparse backing store, untouched lines read as a hash of the address
  logic [data_width-1:0] store [logic [addr_width-1:0]];
  logic [addr_width-1:0] read_addr = '0;
  int                    countdown = 0;
  logic                  resp_pulse = 1'b0;
  logic [data_width-1:0] resp_word = '0;

  assign mem_req_ready  = !stall;
  assign mem_resp_valid = resp_pulse;
  assign mem_resp_data  = resp_word;

  function automatic logic [data_width-1:0] fill_word(input logic [addr_width-1:0] a);
    return {a ^ 16'hc3a5, a * 16'h9e37 + 16'h1234, ~a, a + 16'h7f01};
  endfunction

  function automatic logic [data_width-1:0] read_word(input logic [addr_width-1:0] a);
    if (store.exists(a)) begin
      return store[a];
    end
    return fill_word(a);
  endfunction

  // accept requests; reads answer three cycles later
  always @(posedge clock) begin
    if (reset) begin
      countdown = 0;
    end else if (mem_req_valid && mem_req_ready) begin
      if (mem_req_write) begin
        store[mem_req_addr] = mem_req_data;
      end else begin
        read_addr = mem_req_addr;
        countdown = 3;
      end
    end else if (countdown > 0) begin
      countdown = countdown - 1;
    end
  end

  // response pulse changes away from the sampling edge
  always @(negedge clock) begin
    resp_pulse = countdown == 1;
    if (countdown == 1) begin
      resp_word = read_word(read_addr);
    end
  end

endmodule

/* bench/dcache_tb.sv */
// data cache testbench

`timescale 1ns/10ps

module dcache_tb
  import dcache_pkg::*;
();

  typedef enum {ready_random, ready_low, ready_high} ready_mode_t;

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  req_valid;
  logic                  req_ready;
  cache_op_t             req_op;
  logic [addr_width-1:0] req_addr;
  logic [data_width-1:0] req_data;
  logic                  resp_valid;
  logic                  resp_ready;
  logic [data_width-1:0] resp_data;
  logic                  mem_req_valid;
  logic                  mem_req_ready;
  logic                  mem_req_write;
  logic [addr_width-1:0] mem_req_addr;
  logic [data_width-1:0] mem_req_data;
  logic                  mem_resp_valid;
  logic [data_width-1:0] mem_resp_data;
  logic                  mem_stall;

  logic [31:0] rng_state = 32'd71749;
  ready_mode_t ready_mode = ready_high;
  int          wait_limit = 200;
  int          errors = 0;
  int          checks = 0;
  bit          timed_out = 1'b0;

  // reference model: cache directory, tree bits, memory contents
  logic                  model_valid [num_sets][num_ways];
  logic                  model_dirty [num_sets][num_ways];
  logic [tag_bits-1:0]   model_tag   [num_sets][num_ways];
  logic                  lru_a [num_sets];
  logic                  lru_b [num_sets];
  logic                  lru_c [num_sets];
  logic [data_width-1:0] arch_mem [logic [addr_width-1:0]];

  // expected traffic, oldest first
  logic [data_width-1:0] exp_resp [$];
  logic                  exp_mem_write [$];
  logic [addr_width-1:0] exp_mem_addr [$];
  logic [data_width-1:0] exp_mem_data [$];

  always #2 clock = ~clock;

  dcache_top uut (
    .clock          (clock),
    .reset          (reset),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_op         (req_op),
    .req_addr       (req_addr),
    .req_data       (req_data),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_data      (resp_data),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .mem_req_data   (mem_req_data),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data)
  );

  bench_mem u_mem (
    .clock          (clock),
    .reset          (reset),
    .stall          (mem_stall),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .mem_req_data   (mem_req_data),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data)
  );

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // same address hash the memory starts from
  function automatic logic [data_width-1:0] fill_word(input logic [addr_width-1:0] a);
    return {a ^ 16'hc3a5, a * 16'h9e37 + 16'h1234, ~a, a + 16'h7f01};
  endfunction

  function automatic logic [data_width-1:0] arch_read(input logic [addr_width-1:0] line);
    if (arch_mem.exists(line)) begin
      return arch_mem[line];
    end
    return fill_word(line);
  endfunction

  // six tags on three sets, more tags than ways
  function automatic logic [addr_width-1:0] pick_address();
    logic [31:0] r;
    int          t;
    int          s;
    r = next_random();
    t = int'(r % 32'd6);
    s = int'((r >> 8) % 32'd3);
    return {tag_bits'(t * 41 + 3), index_bits'(s * 5), r[18:16]};
  endfunction

  task automatic compare_data(input string name, input logic [data_width-1:0] expected,
                              input logic [data_width-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_addr(input string name, input logic [addr_width-1:0] expected,
                              input logic [addr_width-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("timeout: %s", what);
  endtask

  function automatic int tree_way(input logic [index_bits-1:0] index);
    if (lru_a[index]) begin
      return lru_c[index] ? 3 : 2;
    end
    return lru_b[index] ? 1 : 0;
  endfunction

  // point the tree away from way w
  task automatic touch_way(input logic [index_bits-1:0] index, input int w);
    lru_a[index] = w < 2;
    if (w < 2) begin
      lru_b[index] = w == 0;
    end else begin
      lru_c[index] = w == 2;
    end
  endtask

  task automatic model_clear();
    for (int s = 0; s < num_sets; s++) begin
      lru_a[s] = 1'b0;
      lru_b[s] = 1'b0;
      lru_c[s] = 1'b0;
      for (int w = 0; w < num_ways; w++) begin
        model_valid[s][w] = 1'b0;
        model_dirty[s][w] = 1'b0;
        model_tag[s][w]   = '0;
      end
    end
  endtask

  // apply one accepted request and queue the traffic it must cause
  task automatic model_access(input cache_op_t op, input logic [addr_width-1:0] a,
                              input logic [data_width-1:0] d);
    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;
    logic [addr_width-1:0] line;
    logic [addr_width-1:0] victim_line;
    int                    way;
    bit                    found;
    index = a[offset_bits +: index_bits];
    tag   = a[addr_width-1 -: tag_bits];
    line  = {a[addr_width-1:offset_bits], {offset_bits{1'b0}}};
    found = 1'b0;
    way   = 0;
    for (int w = 0; w < num_ways; w++) begin
      if (model_valid[index][w] && model_tag[index][w] == tag) begin
        found = 1'b1;
        way   = w;
      end
    end
    if (!found) begin
      way = tree_way(index);
      for (int w = num_ways - 1; w >= 0; w--) begin
        if (!model_valid[index][w]) begin
          way = w;
        end
      end
      if (model_valid[index][way] && model_dirty[index][way]) begin
        victim_line = {model_tag[index][way], index, {offset_bits{1'b0}}};
        exp_mem_write.push_back(1'b1);
        exp_mem_addr.push_back(victim_line);
        exp_mem_data.push_back(arch_read(victim_line));
      end
      if (op == op_load) begin
        exp_mem_write.push_back(1'b0);
        exp_mem_addr.push_back(line);
        exp_mem_data.push_back('0);
      end
      model_valid[index][way] = 1'b1;
      model_tag[index][way]   = tag;
      model_dirty[index][way] = op == op_store;
    end else if (op == op_store) begin
      model_dirty[index][way] = 1'b1;
    end
    if (op == op_store) begin
      arch_mem[line] = d;
    end else begin
      exp_resp.push_back(arch_read(line));
    end
    touch_way(index, way);
  endtask

  // next falling edge, with fresh ready and stall values
  task automatic step();
    @(negedge clock);
    case (ready_mode)
      ready_random: resp_ready = (next_random() % 32'd4) != 32'd0;
      ready_low:    resp_ready = 1'b0;
      default:      resp_ready = 1'b1;
    endcase
    mem_stall = (next_random() % 32'd3) == 32'd0;
  endtask

  task automatic send_request(input cache_op_t op, input logic [addr_width-1:0] a,
                              input logic [data_width-1:0] d);
    int waited;
    bit accepted;
    if (timed_out) begin
      return;
    end
    waited    = 0;
    accepted  = 1'b0;
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = a;
    req_data  = d;
    while (!accepted && waited < wait_limit) begin
      @(posedge clock);
      accepted = req_ready;
      waited++;
      step();
    end
    req_valid = 1'b0;
    if (accepted) begin
      model_access(op, a, d);
    end else begin
      report_timeout("request was never accepted");
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!timed_out && (exp_resp.size() != 0 || exp_mem_addr.size() != 0) &&
           waited < wait_limit) begin
      step();
      waited++;
    end
    if (!timed_out && (exp_resp.size() != 0 || exp_mem_addr.size() != 0)) begin
      report_timeout("outstanding loads or memory requests never completed");
    end
  endtask

  task automatic random_traffic(input int count);
    logic [31:0] r;
    cache_op_t   op;
    for (int i = 0; i < count && !timed_out; i++) begin
      r  = next_random();
      op = r[0] ? op_store : op_load;
      send_request(op, pick_address(), {next_random(), next_random()});
      r = next_random();
      if (r[1:0] == 2'b00) begin
        repeat (int'(r[3:2])) step();
      end
    end
  endtask

  // load twice on an idle pipeline, the second one must hit
  task automatic check_hit_latency(input logic [addr_width-1:0] a);
    int cycles;
    bit seen;
    ready_mode = ready_high;
    send_request(op_load, a, '0);
    wait_drain();
    send_request(op_load, a, '0);
    cycles = 0;
    seen   = 1'b0;
    while (!timed_out && !seen && cycles < wait_limit) begin
      @(posedge clock);
      cycles++;
      seen = resp_valid;
      step();
    end
    if (seen) begin
      // one FIFO cycle, then idle and lookup cycles in the controller
      compare_count("load hit latency", 3, cycles);
    end else if (!timed_out) begin
      report_timeout("no response to a load hit");
    end
  endtask

  task automatic check_back_pressure();
    int waited;
    ready_mode = ready_high;
    wait_drain();
    ready_mode = ready_low;
    // first load parks in the controller, the other two fill the FIFO
    for (int i = 0; i < 3; i++) begin
      send_request(op_load, pick_address(), '0);
    end
    waited = 0;
    while (!timed_out && req_ready && waited < wait_limit) begin
      step();
      waited++;
    end
    if (!timed_out && req_ready) begin
      report_timeout("req_ready never dropped with resp_ready held low");
    end
    for (int i = 0; i < 8 && !timed_out; i++) begin
      step();
      compare_bit("req_ready while FIFO full", 1'b0, req_ready);
    end
    ready_mode = ready_random;
    wait_drain();
  endtask

  // load responses, in request order
  always @(posedge clock) begin : resp_monitor
    logic [data_width-1:0] expected;
    if (!reset && resp_valid && resp_ready) begin
      if (exp_resp.size() == 0) begin
        errors++;
        $display("load response %h arrived with no load outstanding", resp_data);
      end else begin
        expected = exp_resp.pop_front();
        compare_data("load data", expected, resp_data);
      end
    end
  end

  // write-backs and refills against the model's prediction
  always @(posedge clock) begin : mem_monitor
    logic                  expected_write;
    logic [addr_width-1:0] expected_addr;
    logic [data_width-1:0] expected_data;
    if (!reset && mem_req_valid && mem_req_ready) begin
      if (exp_mem_addr.size() == 0) begin
        errors++;
        $display("memory request to %h issued when none was expected", mem_req_addr);
      end else begin
        expected_write = exp_mem_write.pop_front();
        expected_addr  = exp_mem_addr.pop_front();
        expected_data  = exp_mem_data.pop_front();
        compare_bit("memory request write", expected_write, mem_req_write);
        compare_addr("memory request address", expected_addr, mem_req_addr);
        if (expected_write) begin
          compare_data("write-back data", expected_data, mem_req_data);
        end
      end
    end
  end

  initial begin
    reset      = 1'b1;
    req_valid  = 1'b0;
    req_op     = op_load;
    req_addr   = '0;
    req_data   = '0;
    resp_ready = 1'b1;
    mem_stall  = 1'b0;
    model_clear();
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    compare_bit("reset resp_valid", 1'b0, resp_valid);
    compare_bit("reset mem_req_valid", 1'b0, mem_req_valid);
    compare_bit("reset req_ready", 1'b1, req_ready);

    check_hit_latency({tag_bits'(3), index_bits'(0), offset_bits'(0)});

    ready_mode = ready_random;
    random_traffic(400);
    ready_mode = ready_high;
    wait_drain();

    check_hit_latency(pick_address());
    check_back_pressure();

    ready_mode = ready_high;
    wait_drain();
    // late duplicates would show up here
    repeat (10) step();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* list.f */
hw/dcache_pkg.sv
hw/dcache_way.sv
hw/dcache_array.sv
hw/req_fifo.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
bench/bench_mem.sv
bench/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build the data cache testbench with Verilator and run it

verilator --binary --assert --top-module dcache_tb -f list.f -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0
